// File: compile.f
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/reset_sync.sv
hdl/wb_arbiter.sv
hdl/wb_ram.sv
hdl/gpio_regs.sv
hdl/gpio_sampler.sv
hdl/soc_core.sv
hdl/soc_arty.sv
verification/tb_soc_arty.sv

// File: Makefile
TOP := tb_soc_arty
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_soc_arty.sv
// Directed testbench for the Arty SoC top; run through compile.f and the Makefile
`default_nettype none

module tb_soc_arty import soc_bus_pkg::*, soc_map_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Default DUT geometry
  localparam wb_adr_t SAMPLE_BASE    = 32'h0000_0100;
  localparam int      SAMPLE_DEPTH   = 8;
  // RAM words below the ring
  localparam int      LOW_WORDS      = 64;
  localparam int      ACK_LIMIT      = 50;
  // About 110 accesses at ACK_LIMIT each still fit below this
  localparam int      TIMEOUT_CYCLES = 20000;

  logic        clk = 1'b0;
  logic        rst_n;
  wb_req_t     dbg_req;
  wb_rsp_t     dbg_rsp;
  wire  [41:0] ck_io;
  // Bench side of each pin
  logic [41:0] tb_pin_val;
  logic [41:0] tb_pin_en;
  // Pin observation
  logic [41:0] pin_z;
  logic [41:0] pin_lvl;
  int          errors = 0;
  int          cycles = 0;
  // Expected RAM contents below the ring
  wb_dat_t     ram_model [LOW_WORDS];
  // Input patterns applied so far
  logic [31:0] used [$];

  soc_arty soc_arty_i (
    .CLK100MHZ (clk),
    .rst_n     (rst_n),
    .dbg_req   (dbg_req),
    .dbg_rsp   (dbg_rsp),
    .ck_io     (ck_io)
  );

  // 100 ns period
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Pin model
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 42; i++) begin : g_pin
    assign ck_io[i] = tb_pin_en[i] ? tb_pin_val[i] : 1'bz;
    assign pin_z[i] = (ck_io[i] === 1'bz);
  end

  assign pin_lvl = ck_io;

  ////////////////////////////////////////////////////////////////////////////
  // Run limit and stray ack watch
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d clock cycles", cycles);
      $display("Errors: %0d", errors);
      $display("Test FAILED");
      $finish;
    end
  end

  // Ack only inside a debug cycle, one per access
  always @(negedge clk) begin
    if (rst_n === 1'b1 && !dbg_req.cyc) begin
      assert (!dbg_rsp.ack) else begin
        errors++;
        $display("[ERROR] %0t ns dbg_rsp.ack expected 0 got 1", $time);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  function automatic wb_adr_t gpio_adr(input gpio_ofs_t ofs);
    return GPIO_BASE + wb_adr_t'(ofs);
  endfunction

  function automatic wb_adr_t ram_adr(input logic [5:0] idx);
    return RAM_BASE + wb_adr_t'({idx, 2'b00});
  endfunction

  // Byte lanes with sel set take the new data
  function automatic wb_dat_t merge_bytes(input wb_dat_t old_w, input wb_dat_t new_w,
                                          input wb_sel_t sel);
    wb_dat_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  // Random word never applied to the pins before
  function automatic logic [31:0] fresh_pattern();
    logic [31:0] p;
    logic        hit;
    do begin
      p   = $urandom();
      hit = 1'b0;
      foreach (used[i]) begin
        if (used[i] == p) hit = 1'b1;
      end
    end while (hit);
    used.push_back(p);
    return p;
  endfunction

  // One classic cycle on the debug port
  task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                           input wb_dat_t wdat, output wb_dat_t rdat);
    wb_req_t r;
    int      waited;
    logic    acked;
    r      = '0;
    r.cyc  = 1'b1;
    r.stb  = 1'b1;
    r.we   = we;
    r.adr  = adr;
    r.sel  = sel;
    r.dat  = wdat;
    rdat   = '0;
    waited = 0;
    acked  = 1'b0;
    @(posedge clk);
    dbg_req <= r;
    // Latency varies with the arbiter
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge clk);
      if (dbg_rsp.ack) begin
        acked = 1'b1;
        rdat  = dbg_rsp.dat;
      end else begin
        waited++;
      end
    end
    @(posedge clk);
    dbg_req <= '0;
    assert (acked) else begin
      errors++;
      $display("%0t ns: no ack from DUT for the access to address %h", $time, adr);
    end
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_sel_t sel, input wb_dat_t dat);
    wb_dat_t unused;
    bus_cycle(1'b1, adr, sel, dat, unused);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
    bus_cycle(1'b0, adr, 4'hF, '0, dat);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    wb_dat_t rd;
    @(negedge clk);
    // All GPIO enables cleared
    expect_eq("ck_io floating", {22'h0, ~tb_pin_en}, 64'(pin_z));
    wb_read(gpio_adr(GPIO_OUT_OFS), rd);
    expect_eq("GPIO_OUT", 64'h0, 64'(rd));
    wb_read(gpio_adr(GPIO_OE_OFS), rd);
    expect_eq("GPIO_OE", 64'h0, 64'(rd));
    wb_read(gpio_adr(GPIO_CTRL_OFS), rd);
    expect_eq("GPIO_CTRL", 64'h0, 64'(rd));
    // Undriven bits masked out
    wb_read(gpio_adr(GPIO_IN_OFS), rd);
    expect_eq("GPIO_IN", 64'(tb_pin_val[31:0] & tb_pin_en[31:0]),
              64'(rd & tb_pin_en[31:0]));
  endtask

  task automatic ram_access();
    logic [5:0] addr_list [16];
    logic [5:0] idx;
    wb_dat_t    w;
    wb_dat_t    rd;
    wb_sel_t    sel;
    for (int i = 0; i < 16; i++) begin
      idx          = 6'($urandom_range(LOW_WORDS - 1, 0));
      addr_list[i] = idx;
      w            = $urandom();
      wb_write(ram_adr(idx), 4'hF, w);
      ram_model[idx] = w;
    end
    for (int i = 0; i < 16; i++) begin
      idx = addr_list[i];
      wb_read(ram_adr(idx), rd);
      expect_eq($sformatf("ram[%0d]", idx), 64'(ram_model[idx]), 64'(rd));
    end
    // Partial writes over known words
    for (int i = 0; i < 8; i++) begin
      idx = addr_list[$urandom_range(15, 0)];
      sel = 4'($urandom());
      w   = $urandom();
      wb_write(ram_adr(idx), sel, w);
      ram_model[idx] = merge_bytes(ram_model[idx], w, sel);
      wb_read(ram_adr(idx), rd);
      expect_eq($sformatf("ram[%0d] sel %h", idx, sel), 64'(ram_model[idx]), 64'(rd));
    end
  endtask

  task automatic gpio_output();
    logic [31:0] out_v;
    logic [31:0] oe_v;
    logic [31:0] drv;
    logic [31:0] val;
    wb_dat_t     rd;
    out_v = $urandom();
    oe_v  = $urandom();
    // Bench only drives a subset of the pins the DUT leaves alone
    drv   = ~oe_v & $urandom();
    val   = $urandom();
    @(posedge clk);
    tb_pin_en[31:0]  <= drv;
    tb_pin_val[31:0] <= val;
    wb_write(gpio_adr(GPIO_OUT_OFS), 4'hF, out_v);
    wb_write(gpio_adr(GPIO_OE_OFS), 4'hF, oe_v);
    repeat (3) @(posedge clk);
    @(negedge clk);
    expect_eq("ck_io enabled", 64'(out_v & oe_v), 64'(pin_lvl[31:0] & oe_v));
    expect_eq("ck_io floating", {22'h0, 10'h3ff, ~(oe_v | drv)}, 64'(pin_z));
    wb_read(gpio_adr(GPIO_IN_OFS), rd);
    expect_eq("GPIO_IN", 64'((out_v & oe_v) | (val & drv)), 64'(rd & (oe_v | drv)));
    wb_write(gpio_adr(GPIO_OE_OFS), 4'hF, 32'h0);
  endtask

  task automatic sample_ring();
    logic [31:0] pat [10];
    logic [31:0] exp_ring [SAMPLE_DEPTH];
    wb_dat_t     rd;
    // Bench owns every low pin from here on
    @(posedge clk);
    tb_pin_en[31:0] <= '1;
    repeat (5) @(posedge clk);
    used.push_back(tb_pin_val[31:0]);
    wb_write(gpio_adr(GPIO_CTRL_OFS), 4'hF, 32'h1);
    for (int k = 0; k < 10; k++) begin
      pat[k] = fresh_pattern();
      @(posedge clk);
      tb_pin_val[31:0] <= pat[k];
      repeat (20) @(posedge clk);
    end
    // Oldest two overwritten by the wrap
    for (int k = 0; k < 10; k++) begin
      exp_ring[k % SAMPLE_DEPTH] = pat[k];
    end
    for (int j = 0; j < SAMPLE_DEPTH; j++) begin
      wb_read(SAMPLE_BASE + wb_adr_t'(4 * j), rd);
      expect_eq($sformatf("ring[%0d]", j), 64'(exp_ring[j]), 64'(rd));
    end
    wb_write(gpio_adr(GPIO_CTRL_OFS), 4'hF, 32'h0);
  endtask

  task automatic bus_contention();
    logic [31:0] last_pat;
    logic [5:0]  idx;
    wb_dat_t     w;
    wb_dat_t     rd;
    logic        found;
    wb_write(gpio_adr(GPIO_CTRL_OFS), 4'hF, 32'h1);
    fork
      // New input pattern every 3 clocks
      begin
        for (int k = 0; k < 40; k++) begin
          last_pat = fresh_pattern();
          @(posedge clk);
          tb_pin_val[31:0] <= last_pat;
          repeat (2) @(posedge clk);
        end
      end
      // Debug traffic outside the ring
      begin
        for (int n = 0; n < 12; n++) begin
          idx = 6'($urandom_range(LOW_WORDS - 1, 0));
          w   = $urandom();
          wb_write(ram_adr(idx), 4'hF, w);
          ram_model[idx] = w;
          wb_read(ram_adr(idx), rd);
          expect_eq($sformatf("ram[%0d] under load", idx), 64'(ram_model[idx]), 64'(rd));
        end
      end
    join
    // Let the final pattern land in the ring
    repeat (20) @(posedge clk);
    found = 1'b0;
    for (int j = 0; j < SAMPLE_DEPTH; j++) begin
      wb_read(SAMPLE_BASE + wb_adr_t'(4 * j), rd);
      if (rd === last_pat) found = 1'b1;
    end
    assert (found) else begin
      errors++;
      $display("%0t ns: final input pattern %h missing from the sample ring", $time, last_pat);
    end
    wb_write(gpio_adr(GPIO_CTRL_OFS), 4'hF, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(86259));
    rst_n      = 1'b0;
    dbg_req    = '0;
    tb_pin_val = {10'h0, 32'($urandom())};
    tb_pin_en  = {10'h0, 32'($urandom())};
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Core reset trails by 3 clocks
    repeat (6) @(posedge clk);
    check_reset_state();
    ram_access();
    gpio_output();
    sample_ring();
    bus_contention();
    repeat (4) @(posedge clk);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/soc_arty.sv
// Arty board top wrapping the SoC core, its reset and the tristate GPIO pins
`default_nettype none

module soc_arty import soc_bus_pkg::*; #(
  parameter int unsigned GW           = 32,
  parameter int unsigned RAM_WORDS    = 256,
  parameter wb_adr_t     SAMPLE_BASE  = 32'h0000_0100,
  parameter int unsigned SAMPLE_DEPTH = 8
)(
  input  logic       CLK100MHZ,
  // Board reset, active low
  input  logic       rst_n,
  // Debug bus
  input  wb_req_t    dbg_req,
  output wb_rsp_t    dbg_rsp,
  inout  wire [41:0] ck_io
);

  logic          clk;
  logic          core_rst_n;
  logic [GW-1:0] gpio_o;
  logic [GW-1:0] gpio_e;
  logic [GW-1:0] gpio_i;

  // No PLL, board clock used as is
  assign clk = CLK100MHZ;

  reset_sync reset_sync_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rst_n_sync (core_rst_n)
  );

  soc_core #(
    .GW           (GW),
    .RAM_WORDS    (RAM_WORDS),
    .SAMPLE_BASE  (SAMPLE_BASE),
    .SAMPLE_DEPTH (SAMPLE_DEPTH)
  ) soc_core_i (
    .clk     (clk),
    .rst_n   (core_rst_n),
    .dbg_req (dbg_req),
    .dbg_rsp (dbg_rsp),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e),
    .gpio_i  (gpio_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Pins
  ////////////////////////////////////////////////////////////////////////////

  // Pin level read back as input
  assign gpio_i = ck_io[GW-1:0];

  for (genvar i = 0; i < GW; i++) begin : g_pin
    assign ck_io[i] = gpio_e[i] ? gpio_o[i] : 1'bz;
  end

  // Upper pins unused
  assign ck_io[41:GW] = 'z;

endmodule

`default_nettype wire

// File: hdl/soc_core.sv
// SoC core joining the debug port and GPIO sampler to the RAM and GPIO slaves
`default_nettype none

module soc_core import soc_bus_pkg::*; #(
  parameter int unsigned GW           = 32,
  parameter int unsigned RAM_WORDS    = 256,
  parameter wb_adr_t     SAMPLE_BASE  = 32'h0000_0100,
  parameter int unsigned SAMPLE_DEPTH = 8
)(
  input  logic          clk,
  input  logic          rst_n,
  // Debug master
  input  wb_req_t       dbg_req,
  output wb_rsp_t       dbg_rsp,
  // GPIO
  output logic [GW-1:0] gpio_o,
  output logic [GW-1:0] gpio_e,
  input  logic [GW-1:0] gpio_i
);

  wb_req_t       smp_req;
  wb_rsp_t       smp_rsp;
  wb_req_t       ram_req;
  wb_rsp_t       ram_rsp;
  wb_req_t       gpio_req;
  wb_rsp_t       gpio_rsp;
  logic [GW-1:0] gpio_sync;
  logic          sample_en;

  ////////////////////////////////////////////////////////////////////////////
  // Bus fabric, debug on port 0
  ////////////////////////////////////////////////////////////////////////////

  wb_arbiter wb_arbiter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .m0_req   (dbg_req),
    .m0_rsp   (dbg_rsp),
    .m1_req   (smp_req),
    .m1_rsp   (smp_rsp),
    .ram_req  (ram_req),
    .ram_rsp  (ram_rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp)
  );

  wb_ram #(.RAM_WORDS(RAM_WORDS)) wb_ram_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  gpio_regs #(.GW(GW)) gpio_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (gpio_req),
    .rsp       (gpio_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_e    (gpio_e),
    .gpio_sync (gpio_sync),
    .sample_en (sample_en)
  );

  // Ring buffer writer on port 1
  gpio_sampler #(
    .GW           (GW),
    .SAMPLE_BASE  (SAMPLE_BASE),
    .SAMPLE_DEPTH (SAMPLE_DEPTH)
  ) gpio_sampler_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .gpio_sync (gpio_sync),
    .sample_en (sample_en),
    .req       (smp_req),
    .rsp       (smp_rsp)
  );

endmodule

`default_nettype wire

// File: hdl/gpio_sampler.sv
// Wishbone master logging every change of the synchronized GPIO inputs into a RAM ring
`default_nettype none

module gpio_sampler import soc_bus_pkg::*; #(
  parameter int unsigned GW           = 32,
  parameter wb_adr_t     SAMPLE_BASE  = 32'h0000_0100,
  // Power of two
  parameter int unsigned SAMPLE_DEPTH = 8
)(
  input  logic          clk,
  input  logic          rst_n,
  input  logic [GW-1:0] gpio_sync,
  input  logic          sample_en,
  output wb_req_t       req,
  input  wb_rsp_t       rsp
);

  localparam int unsigned PW = $clog2(SAMPLE_DEPTH);

  typedef enum logic {WAIT, WRITE} smp_state_t;

  smp_state_t    state;
  // Ring slot for the next entry
  logic [PW-1:0] ptr_q;
  // Last recorded value, also the write data
  logic [GW-1:0] last_q;

  ////////////////////////////////////////////////////////////////////////////
  // Change detect FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= WAIT;
      ptr_q <= '0;
    end else begin
      case (state)
        WAIT: begin
          if (sample_en && (gpio_sync != last_q)) state <= WRITE;
        end
        WRITE: begin
          if (rsp.ack) begin
            // Wraps at SAMPLE_DEPTH
            ptr_q <= ptr_q + 1'b1;
            state <= WAIT;
          end
        end
        default: state <= WAIT;
      endcase
    end
  end

  // Track inputs while idle, freeze during a write
  // Changes that land mid-write are picked up on return to WAIT
  always_ff @(posedge clk) begin
    if (state == WAIT) last_q <= gpio_sync;
  end

  // One full word write per entry
  always_comb begin
    req     = '0;
    req.cyc = (state == WRITE);
    req.stb = (state == WRITE);
    req.we  = 1'b1;
    req.sel = 4'hF;
    req.adr = SAMPLE_BASE + (wb_adr_t'(ptr_q) << 2);
    req.dat[GW-1:0] = last_q;
  end

endmodule

`default_nettype wire

// File: hdl/gpio_regs.sv
// GPIO output, enable, input and control registers as a Wishbone slave
`default_nettype none

module gpio_regs import soc_bus_pkg::*, soc_map_pkg::*; #(
  parameter int unsigned GW = 32
)(
  input  logic          clk,
  input  logic          rst_n,
  input  wb_req_t       req,
  output wb_rsp_t       rsp,
  // Pins
  input  logic [GW-1:0] gpio_i,
  output logic [GW-1:0] gpio_o,
  output logic [GW-1:0] gpio_e,
  // Toward the sampler
  output logic [GW-1:0] gpio_sync,
  output logic          sample_en
);

  logic [GW-1:0] out_q;
  logic [GW-1:0] oe_q;
  logic          ctrl_q;
  logic [GW-1:0] sync1_q;
  logic [GW-1:0] sync2_q;
  gpio_ofs_t     ofs;
  wb_dat_t       bmask;
  wb_dat_t       rd_nxt;
  wb_dat_t       rd_q;
  logic          acc;
  logic          ack_q;

  assign ofs = req.adr[7:0];
  assign acc = req.cyc && req.stb && !ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bmask[8*b +: 8] = {8{req.sel[b]}};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q  <= '0;
      oe_q   <= '0;
      ctrl_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= acc;
      if (acc && req.we) begin
        case (ofs)
          GPIO_OUT_OFS:  out_q <= (out_q & ~bmask[GW-1:0]) | (req.dat[GW-1:0] & bmask[GW-1:0]);
          GPIO_OE_OFS:   oe_q  <= (oe_q & ~bmask[GW-1:0]) | (req.dat[GW-1:0] & bmask[GW-1:0]);
          GPIO_CTRL_OFS: if (req.sel[0]) ctrl_q <= req.dat[GPIO_CTRL_SMP_EN];
          // GPIO_IN and unknown offsets drop the write
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Input synchronizer and read data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    sync1_q <= gpio_i;
    sync2_q <= sync1_q;
    if (acc) rd_q <= rd_nxt;
  end

  always_comb begin
    rd_nxt = '0;
    case (ofs)
      GPIO_OUT_OFS:  rd_nxt[GW-1:0] = out_q;
      GPIO_OE_OFS:   rd_nxt[GW-1:0] = oe_q;
      GPIO_IN_OFS:   rd_nxt[GW-1:0] = sync2_q;
      GPIO_CTRL_OFS: rd_nxt[GPIO_CTRL_SMP_EN] = ctrl_q;
      default: ;
    endcase
  end

  assign rsp.ack   = ack_q;
  assign rsp.dat   = rd_q;
  assign gpio_o    = out_q;
  assign gpio_e    = oe_q;
  assign gpio_sync = sync2_q;
  assign sample_en = ctrl_q;

endmodule

`default_nettype wire

// File: hdl/wb_ram.sv
// Single-port word RAM Wishbone slave with byte-select writes and registered ack
`default_nettype none

module wb_ram import soc_bus_pkg::*; #(
  parameter int unsigned RAM_WORDS = 256
)(
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t req,
  output wb_rsp_t rsp
);

  localparam int unsigned AW = $clog2(RAM_WORDS);

  wb_dat_t         mem [RAM_WORDS];
  logic [AW-1:0]   idx;
  logic            acc;
  logic            ack_q;
  wb_dat_t         rd_q;

  // Word index, upper address bits wrap
  assign idx = req.adr[AW+1:2];
  // New access, stb in the ack cycle is ignored
  assign acc = req.cyc && req.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
    end
  end

  // Array and read data
  always_ff @(posedge clk) begin
    if (acc) begin
      if (req.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req.sel[b]) mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
        end
      end
      rd_q <= mem[idx];
    end
  end

  assign rsp.ack = ack_q;
  assign rsp.dat = rd_q;

endmodule

`default_nettype wire

// File: hdl/wb_arbiter.sv
// Round-robin arbiter for two Wishbone masters, decoding to the RAM and GPIO slaves
`default_nettype none

module wb_arbiter import soc_bus_pkg::*, soc_map_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // Masters
  input  wb_req_t m0_req,
  output wb_rsp_t m0_rsp,
  input  wb_req_t m1_req,
  output wb_rsp_t m1_rsp,
  // Slaves
  output wb_req_t ram_req,
  input  wb_rsp_t ram_rsp,
  output wb_req_t gpio_req,
  input  wb_rsp_t gpio_rsp
);

  typedef enum logic [1:0] {IDLE, OWN0, OWN1} arb_state_t;

  arb_state_t state;
  // Port that won the last grant
  logic       last;
  wb_req_t    own_req;
  wb_rsp_t    own_rsp;
  logic       to_gpio;

  ////////////////////////////////////////////////////////////////////////////
  // Grant FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      // Port 0 wins the first tie
      last  <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (m0_req.cyc && (!m1_req.cyc || last)) begin
            state <= OWN0;
            last  <= 1'b0;
          end else if (m1_req.cyc) begin
            state <= OWN1;
            last  <= 1'b1;
          end
        end
        // Hold while the owner keeps cyc
        OWN0: if (!m0_req.cyc) state <= IDLE;
        OWN1: if (!m1_req.cyc) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request decode and response return
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    own_req = (state == OWN1) ? m1_req : m0_req;
    // Nothing reaches a slave without a grant
    if (state == IDLE) begin
      own_req.cyc = 1'b0;
      own_req.stb = 1'b0;
    end
    to_gpio = (own_req.adr[MAP_SEL_BIT] == GPIO_BASE[MAP_SEL_BIT]);
    // Strobes only toward the addressed slave
    ram_req      = own_req;
    ram_req.cyc  = own_req.cyc && !to_gpio;
    ram_req.stb  = own_req.stb && !to_gpio;
    gpio_req     = own_req;
    gpio_req.cyc = own_req.cyc && to_gpio;
    gpio_req.stb = own_req.stb && to_gpio;
    own_rsp = to_gpio ? gpio_rsp : ram_rsp;
    // Waiting master sees ack low
    m0_rsp = '0;
    m1_rsp = '0;
    if (state == OWN0) m0_rsp = own_rsp;
    if (state == OWN1) m1_rsp = own_rsp;
  end

endmodule

`default_nettype wire

// File: hdl/reset_sync.sv
// Filters the board reset and aligns both of its edges to the core clock
`default_nettype none

module reset_sync (
  input  logic clk,
  input  logic rst_n,
  output logic rst_n_sync
);

  // Three stage delay line
  logic [2:0] rst_sr;

  // Low board reset shifts zeros in, high shifts ones
  // Either edge reaches the core 3 clocks later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rst_sr <= {rst_sr[1:0], 1'b0};
    end else begin
      rst_sr <= {rst_sr[1:0], 1'b1};
    end
  end

  // Last stage drives the core
  assign rst_n_sync = rst_sr[2];

endmodule

`default_nettype wire

// File: hdl/soc_map_pkg.sv
// Address map and GPIO register layout used by the decoder, slaves and testbench
`default_nettype none

package soc_map_pkg;

  // Address bit that picks the slave
  localparam int unsigned MAP_SEL_BIT = 28;

  // Slave base addresses
  localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
  localparam logic [31:0] GPIO_BASE = 32'h1000_0000;

  ////////////////////////////////////////////////////////////////////////////
  // GPIO register block
  ////////////////////////////////////////////////////////////////////////////

  // Byte offset inside the GPIO window
  typedef logic [7:0] gpio_ofs_t;

  localparam gpio_ofs_t GPIO_OUT_OFS  = 8'h00;
  localparam gpio_ofs_t GPIO_OE_OFS   = 8'h04;
  // Read only
  localparam gpio_ofs_t GPIO_IN_OFS   = 8'h08;
  localparam gpio_ofs_t GPIO_CTRL_OFS = 8'h0C;

  // Sample enable in GPIO_CTRL
  localparam int unsigned GPIO_CTRL_SMP_EN = 0;

endpackage

`default_nettype wire

// File: hdl/soc_bus_pkg.sv
// Wishbone classic bus shape shared by every master, slave and the testbench
`default_nettype none

package soc_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Plain bus vectors
  ////////////////////////////////////////////////////////////////////////////

  // Byte address
  typedef logic [31:0] wb_adr_t;
  // Data word
  typedef logic [31:0] wb_dat_t;
  // One select bit per data byte
  typedef logic [3:0]  wb_sel_t;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response bundles
  ////////////////////////////////////////////////////////////////////////////

  // Master to arbiter, arbiter to slave (71 bits)
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_sel_t sel;
    wb_dat_t dat;
  } wb_req_t;

  // Slave back to master (33 bits)
  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire
